// File: compile.f
+incdir+logic
logic/nand_pkg.sv
logic/nand_request_latch.sv
logic/nand_op_sequencer.sv
logic/nand_bus_engine.sv
logic/nand_ctrl_top.sv
tb/nand_flash_model.sv
tb/tb_nand_ctrl.sv

// File: logic/nand_bus_engine.sv
`timescale 1ns/100ps
`default_nettype none

`include "nand_settings.svh"

module nand_bus_engine (
    input  logic                clk,
    input  logic                rst_n,
    input  nand_pkg::bus_step_t step,
    input  logic                step_valid,
    output logic                step_done,
    output logic [7:0]          rd_byte,
    input  logic                rb,
    input  logic [7:0]          dq_in,
    output logic [7:0]          dq_out,
    output logic                dq_oe,
    output nand_pkg::bus_pins_t pins
);

    localparam logic [`NAND_CNT_W-1:0] TWP = `NAND_TWP;
    localparam logic [`NAND_CNT_W-1:0] TWC = `NAND_TWC;
    localparam logic [`NAND_CNT_W-1:0] TRP = `NAND_TRP;
    localparam logic [`NAND_CNT_W-1:0] TRC = `NAND_TRC;
    localparam logic [`NAND_CNT_W-1:0] TWB = `NAND_TWB;

    logic [`NAND_CNT_W-1:0] cnt;
    logic                   last_hit;
    logic                   is_cmd;
    logic                   is_addr;
    logic                   is_read;
    logic                   is_wait;
    logic                   ale_hold;   // keeps ale up between row bytes

    assign is_cmd  = step_valid && step.kind == nand_pkg::step_cmd;
    assign is_addr = step_valid && step.kind == nand_pkg::step_addr;
    assign is_read = step_valid && step.kind == nand_pkg::step_read;
    assign is_wait = step_valid && step.kind == nand_pkg::step_wait;

    //////////////////////////////////////////////////////////////////////
    // cycle timing
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (step.kind)
            nand_pkg::step_read: last_hit = (cnt == TRC);
            nand_pkg::step_wait: last_hit = (cnt == TWB) && rb;  // ready after TWB
            default:             last_hit = (cnt == TWC);
        endcase
    end

    assign step_done = step_valid && last_hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cnt <= '0;
        else if (!step_valid || step_done)
            cnt <= '0;
        else if (!is_wait || cnt != TWB)   // wait count parks at TWB
            cnt <= cnt + 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            ale_hold <= 1'b0;
        else if (step_done)
            ale_hold <= is_addr && !step.last_addr;
    end

    // read data is stable by the end of the re_n low phase
    always_ff @(posedge clk) begin
        if (is_read && cnt == TRP - 1'b1)
            rd_byte <= dq_in;
    end

    //////////////////////////////////////////////////////////////////////
    // pin levels
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        pins.cle  = is_cmd;
        pins.ale  = is_addr || ale_hold;
        pins.we_n = !((is_cmd || is_addr) && cnt < TWP);
        pins.re_n = !(is_read && cnt < TRP);
    end

    assign dq_oe  = is_cmd || is_addr;
    assign dq_out = step.data;

endmodule

`default_nettype wire

// File: logic/nand_ctrl_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "nand_settings.svh"

module nand_ctrl_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic [`NAND_OP_W-1:0]   operate,
    input  logic [`NAND_ADDR_W-1:0] nf_addr,
    input  logic                    rb,       // high when flash is ready
    input  logic [7:0]              dq_in,
    output nand_pkg::bus_pins_t     pins,
    output logic [7:0]              dq_out,
    output logic                    dq_oe,
    output logic [31:0]             id,
    output logic [7:0]              status,
    output logic                    done,
    output logic                    busy
);

    nand_pkg::nand_req_t req;
    logic                req_valid;
    nand_pkg::bus_step_t step;
    logic                step_valid;
    logic                step_done;
    logic [7:0]          rd_byte;

    nand_request_latch u_req (
        .clk(clk), .rst_n(rst_n), .start(start), .operate(operate), .nf_addr(nf_addr),
        .done(done), .req(req), .req_valid(req_valid)
    );

    nand_op_sequencer u_seq (
        .clk(clk), .rst_n(rst_n), .req(req), .req_valid(req_valid), .step(step),
        .step_valid(step_valid), .step_done(step_done), .rd_byte(rd_byte),
        .id(id), .status(status), .done(done)
    );

    nand_bus_engine u_bus (
        .clk(clk), .rst_n(rst_n), .step(step), .step_valid(step_valid),
        .step_done(step_done), .rd_byte(rd_byte), .rb(rb), .dq_in(dq_in),
        .dq_out(dq_out), .dq_oe(dq_oe), .pins(pins)
    );

    assign busy = req_valid;

endmodule

`default_nettype wire

// File: logic/nand_op_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "nand_settings.svh"

module nand_op_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  nand_pkg::nand_req_t req,
    input  logic                req_valid,
    output nand_pkg::bus_step_t step,
    output logic                step_valid,
    input  logic                step_done,
    input  logic [7:0]          rd_byte,
    output logic [31:0]         id,
    output logic [7:0]          status,
    output logic                done
);

    logic [2:0] idx;        // position in the step list
    logic [2:0] last_idx;
    logic       running;

    always_comb begin
        case (req.op)
            nand_pkg::op_read_id: last_idx = 3'd5;
            nand_pkg::op_erase:   last_idx = 3'd7;
            default:              last_idx = 3'd1;  // reset and status
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // step lists
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        step.kind      = nand_pkg::step_cmd;
        step.data      = 8'h00;
        step.last_addr = 1'b0;
        case (req.op)
            nand_pkg::op_reset: begin
                if (idx == 3'd0)
                    step.data = `NAND_CMD_RESET;
                else
                    step.kind = nand_pkg::step_wait;
            end
            nand_pkg::op_read_id: begin
                case (idx)
                    3'd0: step.data = `NAND_CMD_READ_ID;
                    3'd1: begin
                        step.kind      = nand_pkg::step_addr;  // single 00 byte
                        step.last_addr = 1'b1;
                    end
                    default: step.kind = nand_pkg::step_read;
                endcase
            end
            nand_pkg::op_read_status: begin
                if (idx == 3'd0)
                    step.data = `NAND_CMD_STATUS;
                else
                    step.kind = nand_pkg::step_read;
            end
            default: begin
                // erase, row address skips bit 8 as on the flash
                case (idx)
                    3'd0: step.data = `NAND_CMD_ERASE1;
                    3'd1: begin
                        step.kind = nand_pkg::step_addr;
                        step.data = req.addr[16:9];
                    end
                    3'd2: begin
                        step.kind = nand_pkg::step_addr;
                        step.data = req.addr[24:17];
                    end
                    3'd3: begin
                        step.kind      = nand_pkg::step_addr;
                        step.data      = {7'b0, req.addr[25]};
                        step.last_addr = 1'b1;
                    end
                    3'd4: step.data = `NAND_CMD_ERASE2;
                    3'd5: step.kind = nand_pkg::step_wait;
                    3'd6: step.data = `NAND_CMD_STATUS;  // status check after erase
                    default: step.kind = nand_pkg::step_read;
                endcase
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idx        <= '0;
            running    <= 1'b0;
            step_valid <= 1'b0;
            done       <= 1'b0;
        end else begin
            done <= step_done && (idx == last_idx);
            if (!running) begin
                if (req_valid && !done) begin  // req_valid still high while done
                    running    <= 1'b1;
                    idx        <= '0;
                    step_valid <= 1'b1;
                end
            end else if (step_done) begin
                step_valid <= 1'b0;            // one idle cycle between steps
                if (idx == last_idx)
                    running <= 1'b0;
                else
                    idx <= idx + 3'd1;
            end else if (!step_valid) begin
                step_valid <= 1'b1;
            end
        end
    end

    // id fills from the top byte down as the four reads come in
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id     <= '0;
            status <= '0;
        end else if (step_done && step.kind == nand_pkg::step_read) begin
            if (req.op == nand_pkg::op_read_id)
                id <= {id[23:0], rd_byte};
            else
                status <= rd_byte;
        end
    end

endmodule

`default_nettype wire

// File: logic/nand_pkg.sv
`default_nettype none

`include "nand_settings.svh"

package nand_pkg;

    // operations the controller accepts
    typedef enum logic [1:0] {
        op_reset,
        op_read_id,
        op_read_status,
        op_erase
    } nand_op_e;

    typedef struct packed {
        nand_op_e                 op;
        logic [`NAND_ADDR_W-1:0]  addr;   // flash byte address
    } nand_req_t;

    // one entry of an operation's bus step list
    typedef enum logic [1:0] {
        step_cmd,
        step_addr,
        step_read,
        step_wait    // TWB then wait for ready
    } bus_kind_e;

    typedef struct packed {
        bus_kind_e  kind;
        logic [7:0] data;       // byte for cmd and addr steps
        logic       last_addr;  // ale drops after this step
    } bus_step_t;

    typedef struct packed {
        logic cle;
        logic ale;
        logic we_n;
        logic re_n;
    } bus_pins_t;

endpackage

`default_nettype wire

// File: logic/nand_request_latch.sv
`timescale 1ns/100ps
`default_nettype none

`include "nand_settings.svh"

module nand_request_latch (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic [`NAND_OP_W-1:0]   operate,
    input  logic [`NAND_ADDR_W-1:0] nf_addr,
    input  logic                    done,
    output nand_pkg::nand_req_t     req,
    output logic                    req_valid
);

    nand_pkg::nand_op_e dec_op;
    logic               code_ok;
    logic               accept;

    // only four operate codes survive, the rest are dropped like in idle
    always_comb begin
        code_ok = 1'b1;
        dec_op  = nand_pkg::op_reset;
        case (operate)
            4'b0110: dec_op = nand_pkg::op_reset;
            4'b0111: dec_op = nand_pkg::op_read_id;
            4'b1001: dec_op = nand_pkg::op_read_status;
            4'b0011: dec_op = nand_pkg::op_erase;
            default: code_ok = 1'b0;
        endcase
    end

    assign accept = start && code_ok && !req_valid;  // start ignored while busy

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            req_valid <= 1'b0;
        else if (done)
            req_valid <= 1'b0;
        else if (accept)
            req_valid <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (accept)
            req <= '{op: dec_op, addr: nf_addr};
    end

endmodule

`default_nettype wire

// File: logic/nand_settings.svh
`ifndef NAND_SETTINGS_SVH
`define NAND_SETTINGS_SVH

// bus timing in clk cycles, sized for a 100 MHz clock
`define NAND_TWP 3  // we_n low width
`define NAND_TWC 6  // last count of a write cycle
`define NAND_TRP 4  // re_n low width
`define NAND_TRC 6  // last count of a read cycle
`define NAND_TWB 6  // we_n high to busy

`define NAND_CNT_W  4
`define NAND_OP_W   4
`define NAND_ADDR_W 32

// flash command bytes
`define NAND_CMD_RESET   8'hFF
`define NAND_CMD_READ_ID 8'h90
`define NAND_CMD_STATUS  8'h70
`define NAND_CMD_ERASE1  8'h60
`define NAND_CMD_ERASE2  8'hD0

`endif

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_nand_ctrl -f compile.f -o sim_nand
./obj_dir/sim_nand > sim.log
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: tb/nand_flash_model.sv
`timescale 1ns/100ps
`default_nettype none

`include "nand_settings.svh"

module nand_flash_model (
    input  logic                clk,
    input  logic                rst_n,
    input  nand_pkg::bus_pins_t pins,
    input  logic [7:0]          dq_out,
    output logic [7:0]          dq_in,
    output logic                rb,
    input  logic                clear,        // empties the byte log
    input  logic [31:0]         id_bytes,     // first id byte in the top bits
    input  logic [7:0]          status_byte,
    input  logic [15:0]         busy_len      // rb low cycles after FF or D0
);

    logic [9:0]  log_q [0:15];   // {cle, ale, byte} per we_n rise
    int          n_log;
    int          n_reads;
    logic        we_prev;
    logic        re_prev;
    logic [7:0]  last_cmd;
    logic [1:0]  rd_ptr;
    logic [15:0] busy_cnt;
    logic [7:0]  rd_val;

    always_comb begin
        if (last_cmd == `NAND_CMD_READ_ID) begin
            case (rd_ptr)
                2'd0:    rd_val = id_bytes[31:24];
                2'd1:    rd_val = id_bytes[23:16];
                2'd2:    rd_val = id_bytes[15:8];
                default: rd_val = id_bytes[7:0];
            endcase
        end else begin
            rd_val = status_byte;   // 70 and anything else
        end
    end

    assign dq_in = pins.re_n ? 8'h00 : rd_val;

    // edges show up one clk later, pins and dq_out still hold that cycle's values
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            n_log    <= 0;
            n_reads  <= 0;
            we_prev  <= 1'b1;
            re_prev  <= 1'b1;
            last_cmd <= 8'h00;
            rd_ptr   <= 2'd0;
            busy_cnt <= 16'd0;
            rb       <= 1'b1;
        end else begin
            we_prev <= pins.we_n;
            re_prev <= pins.re_n;
            if (busy_cnt != 16'd0) begin
                busy_cnt <= busy_cnt - 16'd1;
                rb       <= (busy_cnt == 16'd1);
            end
            if (clear) begin
                n_log   <= 0;
                n_reads <= 0;
            end else if (pins.we_n && !we_prev) begin
                if (n_log < 16)
                    log_q[n_log[3:0]] <= {pins.cle, pins.ale, dq_out};
                n_log <= n_log + 1;
                if (pins.cle) begin
                    last_cmd <= dq_out;
                    rd_ptr   <= 2'd0;
                    if ((dq_out == `NAND_CMD_RESET || dq_out == `NAND_CMD_ERASE2)
                            && busy_len != 16'd0) begin
                        busy_cnt <= busy_len;
                        rb       <= 1'b0;
                    end
                end
            end else if (pins.re_n && !re_prev) begin
                n_reads <= n_reads + 1;
                rd_ptr  <= rd_ptr + 2'd1;   // next id byte
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/nand_testdata.txt
// op _ address _ flash id bytes _ flash status _ busy cycles _ exp id _ exp status _ done
// tests run in order, so id and status carry over from one line to the next
9_00000000_ecd35195_e0_0000_00000000_e0_1
7_00000000_ecd35195_e0_0000_ecd35195_e0_1
3_03abcdef_ecd35195_c0_0028_ecd35195_c0_1
6_00000000_11111111_11_0020_ecd35195_c0_1
5_00000000_ecd35195_e0_0000_ecd35195_c0_0
f_ffffffff_ecd35195_e0_0000_ecd35195_c0_0
7_00000000_2cda9015_e0_0000_2cda9015_c0_1
3_02000200_2cda9015_e1_0010_2cda9015_e1_1
9_00000000_2cda9015_60_0000_2cda9015_60_1
6_00000000_2cda9015_60_0005_2cda9015_60_1

// File: tb/tb_nand_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "nand_settings.svh"

module tb_nand_ctrl;

    logic                    clk;
    logic                    rst_n;
    logic                    start;
    logic [`NAND_OP_W-1:0]   operate;
    logic [`NAND_ADDR_W-1:0] nf_addr;
    logic                    rb;
    logic [7:0]              dq_in;
    logic [7:0]              dq_out;
    logic                    dq_oe;
    nand_pkg::bus_pins_t     pins;
    logic [31:0]             id;
    logic [7:0]              status;
    logic                    done;
    logic                    busy;
    logic                    mdl_clear;
    logic [31:0]             mdl_id;
    logic [7:0]              mdl_status;
    logic [15:0]             mdl_busy;

    logic [135:0] vectors [0:15];   // one test per entry, all zero ends the list
    logic [9:0]   exp_log [0:15];   // {cle, ale, byte}
    int           n_exp = 0;
    int           n_tests = 0;
    int           max_busy = 0;
    int           errs = 0;
    int           timing_errs = 0;
    int           passed = 0;
    int           failed = 0;
    int           cycles = 0;
    int           limit = 0;
    int           we_low = 0;
    int           re_low = 0;

    nand_ctrl_top u_dut (
        .clk(clk), .rst_n(rst_n), .start(start), .operate(operate), .nf_addr(nf_addr),
        .rb(rb), .dq_in(dq_in), .pins(pins), .dq_out(dq_out), .dq_oe(dq_oe),
        .id(id), .status(status), .done(done), .busy(busy)
    );

    nand_flash_model u_flash (
        .clk(clk), .rst_n(rst_n), .pins(pins), .dq_out(dq_out), .dq_in(dq_in), .rb(rb),
        .clear(mdl_clear), .id_bytes(mdl_id), .status_byte(mdl_status), .busy_len(mdl_busy)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("timeout: the tests did not finish within %0d cycles", limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // strobe widths and cle/ale at each we_n rise
    //////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (rst_n) begin
            if (!pins.we_n) begin
                we_low++;
            end else begin
                if (we_low != 0) begin
                    assert (we_low == `NAND_TWP) else begin
                        $display("** Error at %0t: we_n low cycles = %0d, expected %0d",
                                 $time, we_low, `NAND_TWP);
                        timing_errs++;
                    end
                    assert (pins.cle != pins.ale && dq_oe) else begin
                        $display(
                            "** Error at %0t: cle = %b ale = %b dq_oe = %b, expected one-hot, 1",
                            $time, pins.cle, pins.ale, dq_oe);
                        timing_errs++;
                    end
                end
                we_low = 0;
            end
            if (!pins.re_n) begin
                re_low++;
            end else begin
                if (re_low != 0) begin
                    assert (re_low == `NAND_TRP) else begin
                        $display("** Error at %0t: re_n low cycles = %0d, expected %0d",
                                 $time, re_low, `NAND_TRP);
                        timing_errs++;
                    end
                end
                re_low = 0;
            end
        end
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got == want) else begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, want);
            errs++;
        end
    endtask

    task automatic push_expected(input logic is_cmd, input logic [7:0] b);
        exp_log[n_exp[3:0]] = {is_cmd, !is_cmd, b};
        n_exp++;
    endtask

    // bus bytes each operation must put on the flash
    task automatic build_expected(input logic [3:0] op, input logic [31:0] addr);
        n_exp = 0;
        case (op)
            4'b0110: push_expected(1'b1, 8'hFF);
            4'b0111: begin
                push_expected(1'b1, 8'h90);
                push_expected(1'b0, 8'h00);
            end
            4'b1001: push_expected(1'b1, 8'h70);
            4'b0011: begin
                push_expected(1'b1, 8'h60);
                push_expected(1'b0, addr[16:9]);   // row bytes, bit 8 skipped
                push_expected(1'b0, addr[24:17]);
                push_expected(1'b0, {7'b0, addr[25]});
                push_expected(1'b1, 8'hD0);
                push_expected(1'b1, 8'h70);
            end
            default: ;
        endcase
    endtask

    task automatic run_test(input int t);
        logic [135:0] v;
        logic [3:0]   op;
        logic [31:0]  addr;
        logic         want_done;
        logic         saw_rb_low;
        logic         rb_at_done;
        logic         saw_busy;
        int           n_done;
        int           err0;
        v          = vectors[t[3:0]];
        op         = v[135:132];
        addr       = v[131:100];
        want_done  = v[0];
        saw_rb_low = 1'b0;
        rb_at_done = 1'b1;
        saw_busy   = 1'b0;
        n_done     = 0;
        err0       = errs + timing_errs;
        build_expected(op, addr);
        mdl_id     = v[99:68];
        mdl_status = v[67:60];
        mdl_busy   = v[59:44];
        mdl_clear  = 1'b1;
        @(negedge clk);
        mdl_clear = 1'b0;
        start     = 1'b1;
        operate   = op;
        nf_addr   = addr;
        @(negedge clk);
        start = 1'b0;
        if (want_done) begin
            @(negedge clk);
            check_eq("busy", {31'b0, busy}, 1);
            start   = 1'b1;          // second request, must be dropped
            operate = 4'b0110;
            nf_addr = ~addr;
            @(negedge clk);
            start = 1'b0;
            while (n_done == 0) begin
                @(negedge clk);
                if (!rb)
                    saw_rb_low = 1'b1;
                if (done) begin
                    n_done++;
                    rb_at_done = rb;
                end
            end
            repeat (20) begin
                @(negedge clk);
                if (done)
                    n_done++;
            end
            if (v[59:44] != 16'd0) begin
                assert (saw_rb_low) else begin
                    $display("flash never went busy during the operation");
                    errs++;
                end
            end
            assert (rb_at_done) else begin
                $display("done came while the flash was still busy");
                errs++;
            end
        end else begin
            repeat (100) begin
                @(negedge clk);
                if (done)
                    n_done++;
                if (busy)
                    saw_busy = 1'b1;
            end
            assert (!saw_busy) else begin
                $display("an ignored operate code made the controller busy");
                errs++;
            end
            check_eq("read strobes", u_flash.n_reads, 0);
        end
        check_eq("done pulses", n_done, {31'b0, want_done});
        check_eq("busy", {31'b0, busy}, 0);
        check_eq("id", id, v[43:12]);
        check_eq("status", {24'h0, status}, {24'h0, v[11:4]});
        check_eq("bus byte count", u_flash.n_log, n_exp);
        for (int i = 0; i < n_exp && i < u_flash.n_log; i++)
            check_eq($sformatf("bus byte %0d", i), {22'h0, u_flash.log_q[i[3:0]]},
                     {22'h0, exp_log[i[3:0]]});
        if (errs + timing_errs == err0) begin
            passed++;
            $display("test %0d operate %h: ok", t, op);
        end else begin
            failed++;
            $display("test %0d operate %h: failed", t, op);
        end
    endtask

    initial begin
        rst_n      = 1'b0;
        start      = 1'b0;
        operate    = '0;
        nf_addr    = '0;
        mdl_clear  = 1'b0;
        mdl_id     = '0;
        mdl_status = '0;
        mdl_busy   = '0;
        for (int k = 0; k < 16; k++)
            vectors[k[3:0]] = '0;
        $readmemh("tb/nand_testdata.txt", vectors);
        while (n_tests < 16 && vectors[n_tests[3:0]] != '0) begin
            if (int'(vectors[n_tests[3:0]][59:44]) > max_busy)
                max_busy = int'(vectors[n_tests[3:0]][59:44]);
            n_tests++;
        end
        limit = n_tests * (200 + max_busy);
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        if (n_tests == 0) begin
            $display("no tests found in tb/nand_testdata.txt");
            errs++;
        end
        for (int t = 0; t < n_tests; t++)
            run_test(t);
        $display("%0d tests, %0d passed, %0d failed, %0d check errors, %0d timing errors",
                 n_tests, passed, failed, errs, timing_errs);
        if (errs == 0 && timing_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
